// ==== hdl/boardPanel.sv ====
`timescale 1ns/10ps
`include "panel_cfg.svh"

module boardPanel
(
   input  logic               selected_clk,
   input  logic               res,
   input  logic [4:0]         btn,
   input  logic [15:0]        sw,
   input  panelPkg::wordT     portA,
   input  panelPkg::wordT     portB,
   input  panelPkg::wordT     portC,
   input  panelPkg::wordT     portD,
   output logic [15:0]        leds,
   output panelPkg::segT      seg,
   output logic [`DIGITS-1:0] an
);

   logic              scanTick;
   logic              sampleTick;
   logic [15:0]       swQ;
   logic              panelRes;
   logic              dispRes;
   panelPkg::viewSelT viewSel;
   logic              direct;
   panelPkg::wordT    viewWord;

   assign dispRes = res | panelRes;             // Button reset only clears the counter view

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Timing and inputs
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   tickGen tickGen_inst
   (
      .selected_clk (selected_clk),
      .res          (res),
      .scanTick     (scanTick),
      .sampleTick   (sampleTick)
   );

   inputSampler inputSampler_inst
   (
      .selected_clk (selected_clk),
      .res          (res),
      .sampleTick   (sampleTick),
      .btn          (btn),
      .sw           (sw),
      .btnQ         (),                         // Feeds the CPU input port
      .swQ          (swQ),
      .panelRes     (panelRes)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Display path
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   panelRegs panelRegs_inst
   (
      .selected_clk (selected_clk),
      .res          (res),
      .swQ          (swQ),
      .viewSel      (viewSel),
      .direct       (direct)
   );

   displaySource displaySource_inst
   (
      .selected_clk (selected_clk),
      .res          (dispRes),
      .portA        (portA),
      .portB        (portB),
      .portC        (portC),
      .portD        (portD),
      .viewSel      (viewSel),
      .viewWord     (viewWord)
   );

   segScan segScan_inst
   (
      .selected_clk (selected_clk),
      .res          (res),
      .scanTick     (scanTick),
      .direct       (direct),
      .viewWord     (viewWord),
      .pixels       ({portD, portC}),
      .seg          (seg),
      .an           (an)
   );

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         leds <= '0;
      else
         leds <= portB[15:0];
   end

endmodule

// ==== hdl/displaySource.sv ====
`timescale 1ns/10ps

module displaySource
(
   input  logic              selected_clk,
   input  logic              res,
   input  panelPkg::wordT    portA,
   input  panelPkg::wordT    portB,
   input  panelPkg::wordT    portC,
   input  panelPkg::wordT    portD,
   input  panelPkg::viewSelT viewSel,
   output panelPkg::wordT    viewWord
);

   panelPkg::wordT cycleCount;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Free-running cycle counter
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         cycleCount <= '0;
      else
         cycleCount <= cycleCount + 1'b1;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // View multiplexer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      case (viewSel)
         panelPkg::PortA:
            viewWord = portA;
         panelPkg::PortB:
            viewWord = portB;
         panelPkg::PortC:
            viewWord = portC;
         panelPkg::PortD:
            viewWord = portD;
         panelPkg::CycleCount:
            viewWord = cycleCount;
         default:
            viewWord = '0;                      // CPU-internal views and direct mode
      endcase
   end

endmodule

// ==== hdl/inputSampler.sv ====
`timescale 1ns/10ps
`include "panel_cfg.svh"

module inputSampler
(
   input  logic        selected_clk,
   input  logic        res,
   input  logic        sampleTick,
   input  logic [4:0]  btn,
   input  logic [15:0] sw,
   output logic [4:0]  btnQ,
   output logic [15:0] swQ,
   output logic        panelRes
);

   localparam int HoldW = $clog2(`RESET_HOLD + 1);

   logic [HoldW-1:0] holdCnt;
   logic             sampled;           // btnQ is fresh this cycle
   logic             bothHeld;
   logic             holdDone;

   assign bothHeld = btnQ[`BTN_C] & btnQ[`BTN_D];
   assign holdDone = (holdCnt == HoldW'(`RESET_HOLD - 1));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Slow sampling acts as the debounce
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         btnQ    <= '0;
         swQ     <= '0;
         sampled <= 1'b0;
      end
      else
      begin
         if (sampleTick)
         begin
            btnQ <= btn;
            swQ  <= sw;
         end
         sampled <= sampleTick;
      end
   end

   // Two-button hold counter that fires once per hold
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         holdCnt  <= '0;
         panelRes <= 1'b0;
      end
      else
      begin
         panelRes <= 1'b0;
         if (sampled)
         begin
            if (!bothHeld)
               holdCnt <= '0;
            else if (holdCnt != HoldW'(`RESET_HOLD))
            begin
               holdCnt  <= holdCnt + 1'b1;
               panelRes <= holdDone;
            end
         end
      end
   end

   assert property (@(posedge selected_clk) disable iff (res) panelRes |=> !panelRes);

endmodule

// ==== hdl/panelPkg.sv ====
package panelPkg;

   typedef logic [31:0] wordT;          // Port or view word
   typedef logic [3:0]  viewSelT;       // View code from the switches
   typedef logic [7:0]  segT;           // Active low, dp in bit 7
   typedef logic [2:0]  digitIdxT;

   // Display view codes, most of them live inside the CPU
   typedef enum viewSelT
   {
      PortA      = 4'd0,
      PortB      = 4'd1,
      PortC      = 4'd2,
      PortD      = 4'd3,
      CycleCount = 4'd4,
      AutoReload = 4'd5,
      Timer      = 4'd6,
      Counter    = 4'd7,
      TestOut    = 4'd8,
      TestReg    = 4'd9,
      Direct     = 4'd10,
      Spare      = 4'd11,
      Irqs       = 4'd12,
      MemIn      = 4'd13,
      MemOut     = 4'd14,
      Address    = 4'd15
   } viewE;

endpackage

// ==== hdl/panelRegs.sv ====
`timescale 1ns/10ps
`include "panel_cfg.svh"

module panelRegs
(
   input  logic              selected_clk,
   input  logic              res,
   input  logic [15:0]       swQ,
   output panelPkg::viewSelT viewSel,
   output logic              direct
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Switch fields
   //   15..12  clock select, fixed in this build
   //   11..8   CPU test output select
   //   7..4    display view
   //   3..0    CPU test register select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   panelPkg::viewSelT viewField;
   logic              isDirect;

   assign viewField = swQ[`VIEW_HI:`VIEW_LO];
   assign isDirect  = (viewField == panelPkg::Direct);   // Raw pixels from C and D

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         viewSel <= panelPkg::PortA;
         direct  <= 1'b0;
      end
      else
      begin
         viewSel <= viewField;
         direct  <= isDirect;
      end
   end

endmodule

// ==== hdl/segScan.sv ====
`timescale 1ns/10ps
`include "panel_cfg.svh"

module segScan
(
   input  logic                 selected_clk,
   input  logic                 res,
   input  logic                 scanTick,
   input  logic                 direct,
   input  panelPkg::wordT       viewWord,
   input  logic [8*`DIGITS-1:0] pixels,
   output panelPkg::segT        seg,
   output logic [`DIGITS-1:0]   an
);

   typedef logic [`DIGITS-1:0] anT;

   panelPkg::digitIdxT digitIdx;
   panelPkg::digitIdxT nextIdx;
   panelPkg::digitIdxT showIdx;         // Digit whose pattern is loaded now
   logic               scanning;
   logic [3:0]         nibble;
   panelPkg::segT      pattern;

   // Active low with segments a..g in bits 0..6 and dp off
   function automatic panelPkg::segT hexSeg(input logic [3:0] nib);
      panelPkg::segT s;
      case (nib)
         4'h0: s = 8'hC0;
         4'h1: s = 8'hF9;
         4'h2: s = 8'hA4;
         4'h3: s = 8'hB0;
         4'h4: s = 8'h99;
         4'h5: s = 8'h92;
         4'h6: s = 8'h82;
         4'h7: s = 8'hF8;
         4'h8: s = 8'h80;
         4'h9: s = 8'h90;
         4'hA: s = 8'h88;
         4'hB: s = 8'h83;
         4'hC: s = 8'hC6;
         4'hD: s = 8'hA1;
         4'hE: s = 8'h86;
         default: s = 8'h8E;
      endcase
      return s;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Digit select and pattern source
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign nextIdx = (digitIdx == panelPkg::digitIdxT'(`DIGITS - 1)) ? '0 : digitIdx + 1'b1;
   assign showIdx = scanTick ? nextIdx : digitIdx;
   assign nibble  = viewWord[4*showIdx +: 4];
   assign pattern = direct ? pixels[8*showIdx +: 8] : hexSeg(nibble);

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         digitIdx <= panelPkg::digitIdxT'(`DIGITS - 1);   // First step lands on digit 0
         scanning <= 1'b0;
         an       <= '1;
         seg      <= '1;
      end
      else
      begin
         if (scanTick)
         begin
            digitIdx <= nextIdx;
            scanning <= 1'b1;
            an       <= ~(anT'(1) << nextIdx);
         end
         if (scanning || scanTick)
            seg <= pattern;                     // Refreshed every cycle so port changes show
      end
   end

   // Never two digits lit together
   assert property (@(posedge selected_clk) disable iff (res) $countones(~an) <= 1);

endmodule

// ==== hdl/tickGen.sv ====
`timescale 1ns/10ps
`include "panel_cfg.svh"

module tickGen
(
   input  logic selected_clk,
   input  logic res,
   output logic scanTick,
   output logic sampleTick
);

   localparam int Ratio  = `SAMPLE_DIV / `SCAN_DIV;
   localparam int ScanW  = $clog2(`SCAN_DIV);
   localparam int RatioW = $clog2(Ratio);

   logic [ScanW-1:0]  scanCnt;
   logic [RatioW-1:0] ratioCnt;
   logic              scanWrap;
   logic              ratioWrap;

   assign scanWrap  = (scanCnt == ScanW'(`SCAN_DIV - 1));
   assign ratioWrap = (ratioCnt == RatioW'(Ratio - 1));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Divider chain
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         scanCnt  <= '0;
         scanTick <= 1'b0;
      end
      else
      begin
         scanCnt  <= scanWrap ? '0 : scanCnt + 1'b1;
         scanTick <= scanWrap;
      end
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         ratioCnt   <= '0;
         sampleTick <= 1'b0;
      end
      else
      begin
         if (scanWrap)
            ratioCnt <= ratioWrap ? '0 : ratioCnt + 1'b1;   // Counts scan periods
         sampleTick <= scanWrap && ratioWrap;
      end
   end

   assert property (@(posedge selected_clk) disable iff (res) scanTick |=> !scanTick);
   assert property (@(posedge selected_clk) disable iff (res) sampleTick |=> !sampleTick);

endmodule

// ==== include/panel_cfg.svh ====
`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe rates in selected_clk cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SCAN_DIV    4       // One digit step
`define SAMPLE_DIV  40      // Input sample, a decade above the scan

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Buttons and switches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RESET_HOLD  3       // Samples with centre and down held
`define BTN_C       0       // Centre button bit
`define BTN_D       1       // Down button bit
`define VIEW_HI     7       // View code field in the switches
`define VIEW_LO     4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DIGITS      8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module panelTb -f vlog.f -Mdir obj_dir \
   && ./obj_dir/VpanelTb > sim.log 2>&1 \
   || { echo "Build or simulation did not complete, see sim.log"; exit 1; }

grep -qx "SIMULATION PASSED" sim.log \
   && { echo "Result: pass"; exit 0; } \
   || { echo "Result: fail, see sim.log"; exit 1; }

// ==== testbench/clockGen.sv ====
`timescale 1ns/10ps

module clockGen
(
   output logic selected_clk,
   output logic res
);

   initial
   begin
      selected_clk = 1'b0;
      res          = 1'b1;
      repeat (8) @(posedge selected_clk);
      #2 res = 1'b0;                           // Released just after the eighth edge
   end

   always #20 selected_clk = ~selected_clk;     // 40 ns period

endmodule

// ==== testbench/panelTb.sv ====
`timescale 1ns/10ps
`include "panel_cfg.svh"

module panelTb;

   logic                selected_clk;
   logic                res;
   logic [4:0]          btn;
   logic [15:0]         sw;
   panelPkg::wordT      portA;
   panelPkg::wordT      portB;
   panelPkg::wordT      portC;
   panelPkg::wordT      portD;
   logic [15:0]         leds;
   panelPkg::segT       seg;
   logic [`DIGITS-1:0]  an;

   logic [31:0]         rngState = 32'ha316_98b2;
   int                  cycle = 0;
   int                  checks = 0;
   int                  errors = 0;
   panelPkg::segT       scanSeg [`DIGITS];
   int                  scanAt [`DIGITS];

   // Active-high lit segments a..g per hex digit
   localparam logic [6:0] LitSegs [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D,
      7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

   clockGen clockGen_inst
   (
      .selected_clk (selected_clk),
      .res          (res)
   );

   boardPanel boardPanel_inst
   (
      .selected_clk (selected_clk),
      .res          (res),
      .btn          (btn),
      .sw           (sw),
      .portA        (portA),
      .portB        (portB),
      .portC        (portC),
      .portD        (portD),
      .leds         (leds),
      .seg          (seg),
      .an           (an)
   );

   always @(posedge selected_clk)
      cycle <= cycle + 1;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model and helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] randWord();
      rngState = rngState ^ (rngState << 13);  // xorshift32
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic panelPkg::segT hexPattern(input logic [3:0] nib);
      return {1'b1, ~LitSegs[nib]};            // Dp off
   endfunction

   function automatic logic [63:0] hexSegs(input logic [31:0] w);
      logic [63:0] r;
      for (int d = 0; d < `DIGITS; d++)
         r[8*d +: 8] = hexPattern(w[4*d +: 4]);
      return r;
   endfunction

   // Valid flag above the decoded nibble
   function automatic logic [4:0] decodeSeg(input panelPkg::segT s);
      logic [4:0] r;
      r = 5'h0;
      for (int n = 0; n < 16; n++)
         if (hexPattern(4'(n)) == s)
            r = {1'b1, 4'(n)};
      return r;
   endfunction

   function automatic logic [31:0] viewModel(input int code);
      case (code)
         0: return portA;
         1: return portB;
         2: return portC;
         3: return portD;
         default: return 32'h0;                // Views that live in the CPU
      endcase
   endfunction

   task automatic compareValue(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   task automatic reportFailure(input string what);
      errors++;
      $display("ERROR %s", what);
   endtask

   task automatic finishTest(input string name, input int c0, input int e0);
      $display("test %-12s %0d checks, %0d errors", name, checks - c0, errors - e0);
   endtask

   task automatic applyInputs(input logic [4:0] b, input logic [15:0] s, input bit newPorts);
      @(posedge selected_clk);
      #2;
      btn = b;
      sw  = s;
      if (newPorts)
      begin
         portA = randWord();
         portB = randWord();
         portC = randWord();
         portD = randWord();
      end
   endtask

   task automatic waitCycles(input int n);
      for (int k = 0; k < n; k++)
         @(posedge selected_clk);
   endtask

   // Record each digit the first time its anode is seen low
   task automatic captureScan(output bit ok);
      logic [`DIGITS-1:0] seen;
      int                 limit;
      int                 idx;
      seen  = '0;
      idx   = 0;
      limit = 2 * `SCAN_DIV * `DIGITS + 4;
      for (int k = 0; k < limit && seen != '1; k++)
      begin
         @(negedge selected_clk);
         if ($countones(~an) == 1)
         begin
            for (int d = 0; d < `DIGITS; d++)
               if (!an[d])
                  idx = d;
            if (!seen[idx])
            begin
               scanSeg[idx] = seg;
               scanAt[idx]  = cycle;
               seen[idx]    = 1'b1;
            end
         end
         else if (an != '1)
            reportFailure("more than one digit enabled at the same time");
      end
      ok = (seen == '1);
      if (!ok)
         reportFailure($sformatf("display did not scan all digits within %0d cycles", limit));
   endtask

   task automatic checkDigits(input string name, input logic [63:0] expSegs);
      bit ok;
      captureScan(ok);
      if (ok)
         for (int d = 0; d < `DIGITS; d++)
            compareValue($sformatf("%s digit%0d", name, d), 64'(expSegs[8*d +: 8]),
                         64'(scanSeg[d]));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic testReset();
      int c0;
      int e0;
      c0 = checks;
      e0 = errors;
      @(negedge selected_clk);
      compareValue("reset an", 64'(8'hFF), 64'(an));
      compareValue("reset seg", 64'(8'hFF), 64'(seg));
      for (int k = 0; k < 16 && res; k++)
         @(negedge selected_clk);
      if (res)
         reportFailure("reset was still active after 16 cycles");
      compareValue("after reset an", 64'(8'hFF), 64'(an));
      compareValue("after reset seg", 64'(8'hFF), 64'(seg));
      compareValue("after reset leds", 64'(0), 64'(leds));
      finishTest("reset", c0, e0);
   endtask

   task automatic testViews(input string name, input int first, input int last);
      int          c0;
      int          e0;
      logic [15:0] s;
      c0 = checks;
      e0 = errors;
      for (int v = first; v <= last; v++)
      begin
         if (v == panelPkg::CycleCount)
            continue;
         s = 16'(randWord());
         s[`VIEW_HI:`VIEW_LO] = 4'(v);
         applyInputs(5'b0, s, 1'b1);
         waitCycles(`SAMPLE_DIV + 3);           // Switch to view bound
         checkDigits($sformatf("view%0d", v), (v == panelPkg::Direct) ? {portD, portC}
                     : hexSegs(viewModel(v)));
         applyInputs(5'b0, s, 1'b1);
         waitCycles(`SCAN_DIV + 2);             // Port to segment bound
         checkDigits($sformatf("view%0d newPorts", v), (v == panelPkg::Direct)
                     ? {portD, portC} : hexSegs(viewModel(v)));
      end
      finishTest(name, c0, e0);
   endtask

   task automatic testLeds();
      int c0;
      int e0;
      c0 = checks;
      e0 = errors;
      for (int r = 0; r < 8; r++)
      begin
         applyInputs(btn, sw, 1'b1);
         @(posedge selected_clk);
         @(negedge selected_clk);
         compareValue("leds", 64'(portB[15:0]), 64'(leds));
      end
      finishTest("leds", c0, e0);
   endtask

   task automatic testHoldReset();
      int          c0;
      int          e0;
      logic [15:0] s;
      logic [4:0]  dec;
      bit          ok;
      bit          high;
      int          holdStart;
      int          elapsed;
      c0 = checks;
      e0 = errors;
      s = 16'(randWord());
      s[`VIEW_HI:`VIEW_LO] = panelPkg::CycleCount;
      applyInputs(5'b0, s, 1'b0);
      waitCycles(`SAMPLE_DIV + 3);
      captureScan(ok);
      high = 1'b0;
      for (int d = 2; d < `DIGITS; d++)
         if (scanSeg[d] != hexPattern(4'h0))
            high = 1'b1;
      if (ok && !high)
         reportFailure("cycle count was below 256 before the buttons were held");
      applyInputs(5'((1 << `BTN_C) | (1 << `BTN_D)), s, 1'b0);
      holdStart = cycle;
      waitCycles((`RESET_HOLD + 1) * `SAMPLE_DIV);
      applyInputs(5'b0, s, 1'b0);
      captureScan(ok);
      if (ok)
      begin
         for (int d = 2; d < `DIGITS; d++)
            compareValue($sformatf("count digit%0d", d), 64'(hexPattern(4'h0)),
                         64'(scanSeg[d]));
         dec     = decodeSeg(scanSeg[1]);
         elapsed = scanAt[1] - holdStart;
         // Pulse lands between two and three sample periods into the hold
         if (!dec[4])
            reportFailure("count digit 1 shows no hex pattern");
         else if (int'(dec[3:0]) > elapsed / 16 ||
                  int'(dec[3:0]) < (elapsed - `RESET_HOLD * `SAMPLE_DIV - 8) / 16)
            reportFailure($sformatf("count digit 1 is %0h, %0d cycles after the hold began",
                                    dec[3:0], elapsed));
      end
      finishTest("holdReset", c0, e0);
   endtask

   initial
   begin
      btn   = '0;
      sw    = '0;
      portA = '0;
      portB = '0;
      portC = '0;
      portD = '0;
      testReset();
      testViews("portViews", 0, 3);
      testViews("direct", panelPkg::Direct, panelPkg::Direct);
      testLeds();
      testViews("unusedViews", 5, 15);          // Direct is rechecked on the way
      testHoldReset();
      $display("totals: 6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/panelPkg.sv
hdl/tickGen.sv
hdl/inputSampler.sv
hdl/panelRegs.sv
hdl/displaySource.sv
hdl/segScan.sv
hdl/boardPanel.sv
testbench/clockGen.sv
testbench/panelTb.sv
